// ==== hw/memPkg.sv ====
`default_nettype none

package memPkg;

    localparam int AddrWidth = 32;
    // RAM index bits, upper address bits are ignored
    localparam int RamAddrBits = 12;
    localparam int InstStep = 4;

    typedef enum logic [1:0] {
        SizeByte = 2'd0,
        SizeHalf = 2'd1,
        SizeWord = 2'd2
    } size_e;

    typedef enum logic [1:0] {
        Idle      = 2'd0,
        ReadInst  = 2'd1,
        ReadData  = 2'd2,
        WriteData = 2'd3
    } arbState_e;

    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } lsuOp_e;

    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [31:0]          wdata;
        size_e                size;
        logic                 write;
    } dataReq_t;

    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [7:0]           wdata;
        logic                 write;
    } ramPort_t;

    typedef struct packed {
        lsuOp_e               op;
        logic [AddrWidth-1:0] addr;
        logic [31:0]          wdata;
    } lsuCmd_t;

endpackage

`default_nettype wire

// ==== hw/byteRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  wire logic             clk,
    input  wire memPkg::ramPort_t ram,
    output logic [7:0]            ramRdata
);

    logic [7:0] mem [0:(1 << memPkg::RamAddrBits) - 1];
    logic [memPkg::RamAddrBits-1:0] index;

    // address wraps inside the array
    assign index = ram.addr[memPkg::RamAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (ram.write) begin
            mem[index] <= ram.wdata;
        end
        // old data on a same-cycle write
        ramRdata <= mem[index];
    end

endmodule

`default_nettype wire

// ==== hw/memArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          ioBufferFull,
    input  wire logic                          fetchReq,
    input  wire logic [memPkg::AddrWidth-1:0]  fetchAddr,
    output logic                               fetchDone,
    output logic [31:0]                        fetchInst,
    input  wire logic                          dataReq,
    input  wire memPkg::dataReq_t              dataReqInfo,
    output logic                               dataDone,
    output logic [31:0]                        dataRdata,
    output memPkg::ramPort_t                   ram,
    input  wire logic [7:0]                    ramRdata
);

    memPkg::arbState_e state;
    memPkg::dataReq_t  cur;
    logic [2:0]        cnt;
    logic [2:0]        numBytes;
    logic              pend;
    logic [1:0]        capIdx;
    logic [31:0]       word;
    logic              reading;
    logic              issuing;
    logic              lastWrite;
    logic              readDone;
    logic              finish;
    logic              accept;

    always_comb begin
        case (cur.size)
            memPkg::SizeByte: numBytes = 3'd1;
            memPkg::SizeHalf: numBytes = 3'd2;
            default:          numBytes = 3'd4;
        endcase
    end

    assign reading = state == memPkg::ReadInst || state == memPkg::ReadData;
    // a byte address goes out this cycle
    assign issuing = reading && cnt != numBytes;
    assign lastWrite = state == memPkg::WriteData && cnt == numBytes - 3'd1;
    assign readDone = reading && cnt == numBytes;
    assign finish = !ioBufferFull && (lastWrite || readDone);

    // no new grant while a done pulse is still out, the client drops its request next cycle
    assign accept = state == memPkg::Idle && !ioBufferFull && !fetchDone && !dataDone
        && (dataReq || fetchReq);

    // byte returned now belongs to the previous counter value
    assign capIdx = cnt[1:0] - 2'd1;

    always_comb begin
        ram.addr  = cur.addr + memPkg::AddrWidth'(cnt);
        ram.wdata = cur.wdata[{cnt[1:0], 3'b000} +: 8];
        ram.write = state == memPkg::WriteData && !ioBufferFull;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= memPkg::Idle;
            cnt       <= 3'd0;
            pend      <= 1'b0;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else begin
            fetchDone <= finish && state == memPkg::ReadInst;
            dataDone  <= finish && state != memPkg::ReadInst;
            // frozen issues are not captured, the same byte goes out again
            pend <= issuing && !ioBufferFull;
            if (accept) begin
                cnt <= 3'd0;
                if (dataReq) begin
                    state <= dataReqInfo.write ? memPkg::WriteData : memPkg::ReadData;
                end else begin
                    state <= memPkg::ReadInst;
                end
            end else if (finish) begin
                state <= memPkg::Idle;
            end else if (!ioBufferFull && (issuing || state == memPkg::WriteData)) begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    // latched request and assembled read word
    always_ff @(posedge clk) begin
        if (accept) begin
            word <= '0;
            if (dataReq) begin
                cur <= dataReqInfo;
            end else begin
                cur <= '{
                    addr:  fetchAddr,
                    wdata: 32'd0,
                    size:  memPkg::SizeWord,
                    write: 1'b0
                };
            end
        end else if (pend) begin
            word[{capIdx, 3'b000} +: 8] <= ramRdata;
        end
    end

    // little-endian, upper bytes stay zero for short reads
    assign fetchInst = word;
    assign dataRdata = word;

endmodule

`default_nettype wire

// ==== hw/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         redirectValid,
    input  wire logic [memPkg::AddrWidth-1:0] redirectPc,
    output logic                              fetchReq,
    output logic [memPkg::AddrWidth-1:0]      fetchAddr,
    input  wire logic                         fetchDone,
    input  wire logic [31:0]                  fetchInst,
    output logic                              instValid,
    output logic [31:0]                       instData,
    output logic [memPkg::AddrWidth-1:0]      instPc,
    input  wire logic                         instReady
);

    logic [memPkg::AddrWidth-1:0] pc;
    logic discard;
    logic consumed;
    logic canRequest;

    assign consumed = instValid && instReady;
    // buffer is empty again by the time the word lands
    assign canRequest = !fetchReq && (!instValid || consumed);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            fetchReq  <= 1'b0;
            instValid <= 1'b0;
            discard   <= 1'b0;
        end else if (redirectValid) begin
            pc        <= redirectPc;
            instValid <= 1'b0;
            // in-flight fetch still has to finish its handshake
            fetchReq  <= fetchReq && !fetchDone;
            discard   <= fetchReq && !fetchDone;
        end else if (fetchDone) begin
            fetchReq  <= 1'b0;
            discard   <= 1'b0;
            instValid <= !discard;
            if (!discard) begin
                pc <= pc + memPkg::AddrWidth'(memPkg::InstStep);
            end
        end else begin
            if (consumed) begin
                instValid <= 1'b0;
            end
            if (canRequest) begin
                fetchReq <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (canRequest) begin
            fetchAddr <= pc;
        end
        if (fetchDone) begin
            instData <= fetchInst;
            instPc   <= fetchAddr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             lsuCmdValid,
    input  wire memPkg::lsuCmd_t  lsuCmd,
    output logic                  lsuCmdReady,
    output logic                  dataReq,
    output memPkg::dataReq_t      dataReqInfo,
    input  wire logic             dataDone,
    input  wire logic [31:0]      dataRdata,
    output logic                  lsuRespValid,
    output logic [31:0]           lsuRespData
);

    memPkg::lsuOp_e op;
    memPkg::size_e  cmdSize;
    logic           cmdWrite;
    logic           accept;
    logic [31:0]    loadData;

    always_comb begin
        case (lsuCmd.op)
            memPkg::LB, memPkg::LBU, memPkg::SB: cmdSize = memPkg::SizeByte;
            memPkg::LH, memPkg::LHU, memPkg::SH: cmdSize = memPkg::SizeHalf;
            default:                             cmdSize = memPkg::SizeWord;
        endcase
        cmdWrite = lsuCmd.op inside {memPkg::SB, memPkg::SH, memPkg::SW};
    end

    // one command at a time, busy until its done
    assign lsuCmdReady = !dataReq;
    assign accept = lsuCmdValid && lsuCmdReady;

    always_comb begin
        case (op)
            memPkg::LB:  loadData = {{24{dataRdata[7]}}, dataRdata[7:0]};
            memPkg::LH:  loadData = {{16{dataRdata[15]}}, dataRdata[15:0]};
            memPkg::LBU: loadData = {24'd0, dataRdata[7:0]};
            memPkg::LHU: loadData = {16'd0, dataRdata[15:0]};
            default:     loadData = dataRdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataReq      <= 1'b0;
            lsuRespValid <= 1'b0;
        end else begin
            // stores complete silently
            lsuRespValid <= dataDone && !dataReqInfo.write;
            if (dataDone) begin
                dataReq <= 1'b0;
            end else if (accept) begin
                dataReq <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op <= lsuCmd.op;
            dataReqInfo <= '{
                addr:  lsuCmd.addr,
                wdata: lsuCmd.wdata,
                size:  cmdSize,
                write: cmdWrite
            };
        end
        if (dataDone) begin
            lsuRespData <= loadData;
        end
    end

endmodule

`default_nettype wire

// ==== hw/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         ioBufferFull,
    input  wire logic                         redirectValid,
    input  wire logic [memPkg::AddrWidth-1:0] redirectPc,
    output logic                              instValid,
    output logic [31:0]                       instData,
    output logic [memPkg::AddrWidth-1:0]      instPc,
    input  wire logic                         instReady,
    input  wire logic                         lsuCmdValid,
    input  wire memPkg::lsuCmd_t              lsuCmd,
    output logic                              lsuCmdReady,
    output logic                              lsuRespValid,
    output logic [31:0]                       lsuRespData
);

    logic                         fetchReq;
    logic [memPkg::AddrWidth-1:0] fetchAddr;
    logic                         fetchDone;
    logic [31:0]                  fetchInst;
    logic                         dataReq;
    memPkg::dataReq_t             dataReqInfo;
    logic                         dataDone;
    logic [31:0]                  dataRdata;
    memPkg::ramPort_t             ram;
    logic [7:0]                   ramRdata;

    memArbiter arb (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .fetchReq     (fetchReq),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataReq      (dataReq),
        .dataReqInfo  (dataReqInfo),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .ram          (ram),
        .ramRdata     (ramRdata)
    );

    fetchUnit ifu (
        .clk           (clk),
        .rst           (rst),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .fetchReq      (fetchReq),
        .fetchAddr     (fetchAddr),
        .fetchDone     (fetchDone),
        .fetchInst     (fetchInst),
        .instValid     (instValid),
        .instData      (instData),
        .instPc        (instPc),
        .instReady     (instReady)
    );

    loadStoreUnit lsu (
        .clk          (clk),
        .rst          (rst),
        .lsuCmdValid  (lsuCmdValid),
        .lsuCmd       (lsuCmd),
        .lsuCmdReady  (lsuCmdReady),
        .dataReq      (dataReq),
        .dataReqInfo  (dataReqInfo),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .lsuRespValid (lsuRespValid),
        .lsuRespData  (lsuRespData)
    );

    byteRam mem (
        .clk      (clk),
        .ram      (ram),
        .ramRdata (ramRdata)
    );

endmodule

`default_nettype wire

// ==== testbench/memSubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

    localparam int StoreRounds = 30;
    localparam int InstWords = 16;
    localparam int MixedCount = 200;
    localparam int TxnCount = 1024 + 3 + 6 * StoreRounds + 2 * InstWords + 8 + 2 * MixedCount;
    // budget per transaction covers freezes and fetch contention
    localparam int CycleLimit = 40 * TxnCount;

    logic clk;
    logic rst;
    logic ioBufferFull;
    logic redirectValid;
    logic [31:0] redirectPc;
    logic instValid;
    logic [31:0] instData;
    logic [31:0] instPc;
    logic instReady;
    logic lsuCmdValid;
    memPkg::lsuCmd_t lsuCmd;
    logic lsuCmdReady;
    logic lsuRespValid;
    logic [31:0] lsuRespData;

    // byte image of the RAM as left by the issued stores
    logic [7:0] refMem [0:(1 << memPkg::RamAddrBits) - 1];
    logic [31:0] expQ [$];
    logic [31:0] expLoad;
    logic [31:0] expPc = 32'd0;
    logic [15:0] lfsr = 16'd13551;
    logic freezeOn = 1'b0;
    logic streamOn = 1'b0;
    int instCount = 0;
    int cycles = 0;
    string testName = "reset";

    memSubsystem UUT (
        .clk           (clk),
        .rst           (rst),
        .ioBufferFull  (ioBufferFull),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .instValid     (instValid),
        .instData      (instData),
        .instPc        (instPc),
        .instReady     (instReady),
        .lsuCmdValid   (lsuCmdValid),
        .lsuCmd        (lsuCmd),
        .lsuCmdReady   (lsuCmdReady),
        .lsuRespValid  (lsuRespValid),
        .lsuRespData   (lsuRespData)
    );

    function automatic logic randBit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return b;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        int i;
        v = 32'd0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], randBit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] randAddr();
        logic [31:0] hi;
        logic [31:0] lo;
        // upper bits are noise and the low region stays clear of the code area
        hi = randBits(8);
        lo = randBits(10);
        return (hi << 24) | lo;
    endfunction

    function automatic memPkg::lsuOp_e randOp();
        logic [31:0] v;
        v = randBits(3);
        return memPkg::lsuOp_e'(v[2:0]);
    endfunction

    function automatic logic [31:0] expectedLoad(input memPkg::lsuOp_e op,
                                                 input logic [31:0] addr);
        logic [31:0] raw;
        logic [memPkg::RamAddrBits-1:0] idx;
        int k;
        for (k = 0; k < 4; k++) begin
            idx = addr[memPkg::RamAddrBits-1:0] + memPkg::RamAddrBits'(k);
            raw[8*k +: 8] = refMem[idx];
        end
        case (op)
            memPkg::LB:  return {{24{raw[7]}}, raw[7:0]};
            memPkg::LH:  return {{16{raw[15]}}, raw[15:0]};
            memPkg::LBU: return {24'd0, raw[7:0]};
            memPkg::LHU: return {16'd0, raw[15:0]};
            default:     return raw;
        endcase
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch in %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic tick();
        @(negedge clk);
        ioBufferFull = freezeOn && (randBits(2) == 32'd3);
        if (streamOn) begin
            instReady = randBit();
        end
    endtask

    task automatic applyStore(input memPkg::lsuOp_e op, input logic [31:0] addr,
                              input logic [31:0] wdata);
        logic [memPkg::RamAddrBits-1:0] idx;
        int n;
        int k;
        case (op)
            memPkg::SB: n = 1;
            memPkg::SH: n = 2;
            default:    n = 4;
        endcase
        for (k = 0; k < n; k++) begin
            idx = addr[memPkg::RamAddrBits-1:0] + memPkg::RamAddrBits'(k);
            refMem[idx] = wdata[8*k +: 8];
        end
    endtask

    task automatic issue(input memPkg::lsuOp_e op, input logic [31:0] addr,
                         input logic [31:0] wdata);
        lsuCmd = '{op: op, addr: addr, wdata: wdata};
        lsuCmdValid = 1'b1;
        while (!lsuCmdReady) begin
            tick();
        end
        // taken on the coming rising edge
        if (op inside {memPkg::SB, memPkg::SH, memPkg::SW}) begin
            applyStore(op, addr, wdata);
        end else begin
            expQ.push_back(expectedLoad(op, addr));
        end
        tick();
        lsuCmdValid = 1'b0;
        // busy from acceptance until the transfer is done
        check({testName, " ready after accept"}, 32'd0, 32'(lsuCmdReady));
    endtask

    task automatic timedLoad(input memPkg::lsuOp_e op, input logic [31:0] addr,
                             input int expLat);
        int n;
        issue(op, addr, 32'd0);
        n = 0;
        while (!lsuRespValid) begin
            tick();
            n++;
        end
        check("load latency", 32'(expLat), 32'(n));
    endtask

    task automatic redirect(input logic [31:0] pc);
        streamOn = 1'b0;
        instReady = 1'b0;
        redirectPc = pc;
        redirectValid = 1'b1;
        expPc = pc;
        tick();
        redirectValid = 1'b0;
    endtask

    task automatic streamFor(input int count);
        int target;
        target = instCount + count;
        streamOn = 1'b1;
        while (instCount < target) begin
            tick();
        end
        streamOn = 1'b0;
        instReady = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // load responses and delivered instructions against the byte image
    always @(posedge clk) begin
        if (!rst && lsuRespValid) begin
            if (expQ.size() == 0) begin
                failRun("a load response arrived with no load outstanding");
            end else begin
                expLoad = expQ.pop_front();
                check(testName, expLoad, lsuRespData);
            end
        end
        if (!rst && instValid && instReady) begin
            check({testName, " pc"}, expPc, instPc);
            check({testName, " inst"}, expectedLoad(memPkg::LW, expPc), instData);
            expPc = expPc + 32'd4;
            instCount = instCount + 1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CycleLimit) begin
            failRun($sformatf("timeout, the run did not finish in %0d cycles", CycleLimit));
        end
    end

    initial begin
        int i;
        memPkg::lsuOp_e op;
        logic [31:0] addr;
        logic [31:0] data;
        rst = 1'b1;
        ioBufferFull = 1'b0;
        redirectValid = 1'b0;
        redirectPc = 32'd0;
        instReady = 1'b0;
        lsuCmdValid = 1'b0;
        lsuCmd = '0;
        repeat (16) @(negedge clk);
        check("reset ready", 32'd1, 32'(lsuCmdReady));
        check("reset inst valid", 32'd0, 32'(instValid));
        check("reset resp valid", 32'd0, 32'(lsuRespValid));
        rst = 1'b0;

        testName = "fill";
        for (i = 0; i < 1024; i++) begin
            addr = 32'(4 * i);
            issue(memPkg::SW, addr, (addr * 32'h9E37_79B1) ^ 32'h5A3C_0F96);
        end

        testName = "timing";
        timedLoad(memPkg::LW, 32'h124, 7);
        timedLoad(memPkg::LH, 32'h2F1, 5);
        timedLoad(memPkg::LB, 32'h0A7, 4);

        testName = "store then load";
        for (i = 0; i < StoreRounds; i++) begin
            addr = randAddr();
            data = randBits(32);
            case (i % 3)
                0:       op = memPkg::SB;
                1:       op = memPkg::SH;
                default: op = memPkg::SW;
            endcase
            issue(op, addr, data);
            issue(memPkg::LB, addr, 32'd0);
            issue(memPkg::LH, addr, 32'd0);
            issue(memPkg::LW, addr, 32'd0);
            issue(memPkg::LBU, addr, 32'd0);
            issue(memPkg::LHU, addr, 32'd0);
        end

        testName = "stream";
        for (i = 0; i < InstWords; i++) begin
            data = randBits(32);
            issue(memPkg::SW, 32'h800 + 32'(4 * i), data);
        end
        redirect(32'h800);
        streamFor(InstWords + 4);

        // a consume just happened, so the next fetch is in flight
        testName = "redirect in flight";
        redirect(32'hA40);
        streamFor(4);

        testName = "fetch and load";
        while (!(instValid && lsuCmdReady)) begin
            tick();
        end
        instReady = 1'b1;
        lsuCmd = '{op: memPkg::LW, addr: 32'h40, wdata: 32'd0};
        lsuCmdValid = 1'b1;
        expQ.push_back(expectedLoad(memPkg::LW, 32'h40));
        tick();
        instReady = 1'b0;
        lsuCmdValid = 1'b0;
        while (!lsuRespValid && !instValid) begin
            tick();
        end
        check("load before fetch", 32'd1, 32'(lsuRespValid));
        streamFor(1);

        testName = "mixed with freezes";
        redirect(32'h900);
        freezeOn = 1'b1;
        streamOn = 1'b1;
        for (i = 0; i < MixedCount; i++) begin
            op = randOp();
            addr = randAddr();
            data = randBits(32);
            issue(op, addr, data);
        end
        while (expQ.size() != 0) begin
            tick();
        end
        freezeOn = 1'b0;
        streamOn = 1'b0;
        instReady = 1'b0;
        ioBufferFull = 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/memPkg.sv
hw/byteRam.sv
hw/memArbiter.sv
hw/fetchUnit.sv
hw/loadStoreUnit.sv
hw/memSubsystem.sv
testbench/memSubsystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then decide from the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --top-module memSubsystemTb -f files.f > build.log 2>&1 &&
./obj_dir/VmemSubsystemTb > sim.log 2>&1 ||
echo "build or simulation stopped with an error, see build.log and sim.log"
cat sim.log 2>/dev/null
! grep -q "Some tests failed" sim.log && grep -q "All tests passed" sim.log
